/* dcache.f */
src/dcache_pkg.sv
src/dcache_if.sv
src/core_port.sv
src/line_store.sv
src/miss_ctrl.sv
src/mem_port.sv
src/dcache_top.sv
sim/tb_mem_model.sv
sim/tb_dcache.sv

/* sim/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    localparam int    TIMEOUT   = 200;
    localparam addr_t ADDR_A    = 32'h0000_12b0;
    localparam addr_t ADDR_B    = 32'h0000_1ab0;
    localparam addr_t ADDR_D    = 32'h0002_0040;
    localparam addr_t SOAK_BASE = 32'h0004_0100;

    logic    clk_i;
    logic    rst_i;
    logic    req_valid_i;
    mem_op_e req_op_i;
    addr_t   req_addr_i;
    word_t   req_wdata_i;
    logic    req_ready_o;
    logic    rsp_valid_o;
    word_t   rsp_rdata_o;
    logic    mem_req_valid_o;
    logic    mem_req_ready_i;
    logic    mem_req_write_o;
    addr_t   mem_req_addr_o;
    line_t   mem_req_line_o;
    logic    mem_rsp_valid_i;
    line_t   mem_rsp_line_i;
    int      reads;
    int      writes;
    addr_t   last_wr_addr;
    line_t   last_wr_line;

    logic [7:0]  ref_mem [addr_t];
    logic [31:0] rand_q;
    int          errors;
    int          checks;

    dcache_top DUT (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .req_valid_i     (req_valid_i),
        .req_op_i        (req_op_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_rdata_o     (rsp_rdata_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_write_o (mem_req_write_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_line_o  (mem_req_line_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_line_i  (mem_rsp_line_i)
    );

    tb_mem_model u_mem (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .mem_req_valid_i (mem_req_valid_o),
        .mem_req_ready_o (mem_req_ready_i),
        .mem_req_write_i (mem_req_write_o),
        .mem_req_addr_i  (mem_req_addr_o),
        .mem_req_line_i  (mem_req_line_o),
        .mem_rsp_valid_o (mem_rsp_valid_i),
        .mem_rsp_line_o  (mem_rsp_line_i),
        .read_count_o    (reads),
        .write_count_o   (writes),
        .last_wr_addr_o  (last_wr_addr),
        .last_wr_line_o  (last_wr_line)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // stored byte or else the memory fill pattern
    function automatic logic [7:0] ref_byte(input addr_t a);
        word_t w;
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        w = {a[31:2], 2'b00} ^ 32'ha5a5_0000;
        return w[a[1:0]*8 +: 8];
    endfunction

    function automatic int op_size(input mem_op_e op);
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: return 2;
            MEM_LW, MEM_SW:          return 4;
            default:                 return 1;
        endcase
    endfunction

    function automatic word_t expect_load(input mem_op_e op, input addr_t a);
        word_t v;
        v = '0;
        for (int i = 0; i < op_size(op); i++) begin
            v[i*8 +: 8] = ref_byte(a + addr_t'(i));
        end
        if (op == MEM_LB) begin
            v = {{24{v[7]}}, v[7:0]};
        end else if (op == MEM_LH) begin
            v = {{16{v[15]}}, v[15:0]};
        end
        return v;
    endfunction

    function automatic line_t ref_line(input addr_t line_addr);
        line_t l;
        for (int i = 0; i < LINE_BYTES; i++) begin
            l[i*8 +: 8] = ref_byte(line_addr + addr_t'(i));
        end
        return l;
    endfunction

    function automatic mem_op_e pick_op(input logic [2:0] sel);
        case (sel)
            3'd0:    return MEM_LB;
            3'd1:    return MEM_LH;
            3'd2:    return MEM_LW;
            3'd3:    return MEM_LBU;
            3'd4:    return MEM_LHU;
            3'd5:    return MEM_SB;
            3'd6:    return MEM_SH;
            default: return MEM_SW;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic end_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        end_run();
    endtask

    task automatic apply_reset();
        rst_i = 1'b0;
        repeat (4) @(negedge clk_i);
        rst_i = 1'b1;
    endtask

    // one request through the core port with latency in clock cycles
    task automatic run_access(input mem_op_e op, input addr_t a, input word_t d,
                              output word_t rdata, output int lat, output logic gap_ok);
        int n;
        n      = 0;
        gap_ok = 1'b1;
        while (!req_ready_o && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!req_ready_o) begin
            stop_on_timeout("req_ready_o rising");
        end else begin
            req_valid_i = 1'b1;
            req_op_i    = op;
            req_addr_i  = a;
            req_wdata_i = d;
            @(negedge clk_i);
            req_valid_i = 1'b0;
            lat = 0;
            while (!rsp_valid_o && lat < TIMEOUT) begin
                if (req_ready_o) begin
                    gap_ok = 1'b0;
                end
                @(negedge clk_i);
                lat++;
            end
            if (!rsp_valid_o) begin
                stop_on_timeout("rsp_valid_o pulse");
            end else begin
                // ready is back in the response cycle
                if (!req_ready_o) begin
                    gap_ok = 1'b0;
                end
                rdata = rsp_rdata_o;
            end
        end
    endtask

    task automatic access_check(input string name, input mem_op_e op, input addr_t a,
                                input word_t d);
        word_t rdata;
        word_t exp;
        int    lat;
        logic  gap_ok;
        if (op inside {MEM_SB, MEM_SH, MEM_SW}) begin
            for (int i = 0; i < op_size(op); i++) begin
                ref_mem[a + addr_t'(i)] = d[i*8 +: 8];
            end
            exp = '0;
        end else begin
            exp = expect_load(op, a);
        end
        run_access(op, a, d, rdata, lat, gap_ok);
        check_word(name, exp, rdata);
        check_count({name, " ready gap"}, 1, int'(gap_ok));
    endtask

    task automatic compare_reset_outputs(input string name);
        check_count({name, " req_ready_o"}, 1, int'(req_ready_o));
        check_count({name, " rsp_valid_o"}, 0, int'(rsp_valid_o));
        check_count({name, " mem_req_valid_o"}, 0, int'(mem_req_valid_o));
    endtask

    task automatic cold_miss_then_hit();
        int r0;
        int w0;
        r0 = reads;
        w0 = writes;
        access_check("cold lw +0", MEM_LW, ADDR_A, '0);
        check_count("cold read count", r0 + 1, reads);
        access_check("hit lw +8", MEM_LW, ADDR_A + 8, '0);
        access_check("hit lh +0", MEM_LH, ADDR_A, '0);
        access_check("hit lh +6", MEM_LH, ADDR_A + 6, '0);
        access_check("hit lhu +2", MEM_LHU, ADDR_A + 2, '0);
        access_check("hit lhu +14", MEM_LHU, ADDR_A + 14, '0);
        access_check("hit lb +0", MEM_LB, ADDR_A, '0);
        access_check("hit lb +3", MEM_LB, ADDR_A + 3, '0);
        access_check("hit lbu +0", MEM_LBU, ADDR_A, '0);
        access_check("hit lbu +9", MEM_LBU, ADDR_A + 9, '0);
        check_count("cold reads after hits", r0 + 1, reads);
        check_count("cold writes", w0, writes);
    endtask

    task automatic hit_timing();
        word_t rdata;
        int    lat;
        logic  gap_ok;
        run_access(MEM_LW, ADDR_A + 4, '0, rdata, lat, gap_ok);
        check_word("timing lw data", expect_load(MEM_LW, ADDR_A + 4), rdata);
        check_count("timing lw latency", 2, lat);
        check_count("timing lw ready gap", 1, int'(gap_ok));
        run_access(MEM_LBU, ADDR_A + 13, '0, rdata, lat, gap_ok);
        check_word("timing lbu data", expect_load(MEM_LBU, ADDR_A + 13), rdata);
        check_count("timing lbu latency", 2, lat);
        check_count("timing lbu ready gap", 1, int'(gap_ok));
    endtask

    task automatic store_merge();
        int r0;
        int w0;
        r0 = reads;
        w0 = writes;
        access_check("merge sb", MEM_SB, ADDR_A + 1, 32'hdead_be5a);
        access_check("merge sh", MEM_SH, ADDR_A + 6, 32'hcafe_beef);
        access_check("merge sw", MEM_SW, ADDR_A + 8, 32'h1234_5678);
        access_check("merge lw +0", MEM_LW, ADDR_A, '0);
        access_check("merge lw +4", MEM_LW, ADDR_A + 4, '0);
        access_check("merge lw +8", MEM_LW, ADDR_A + 8, '0);
        access_check("merge lh +6", MEM_LH, ADDR_A + 6, '0);
        access_check("merge lbu +1", MEM_LBU, ADDR_A + 1, '0);
        check_count("merge writes", w0, writes);
        check_count("merge reads", r0, reads);
    endtask

    task automatic dirty_eviction();
        int    r0;
        int    w0;
        addr_t line_a;
        line_t old_line;
        r0       = reads;
        w0       = writes;
        line_a   = ADDR_A & ~32'hf;
        old_line = ref_line(line_a);
        access_check("evict lw b", MEM_LW, ADDR_B, '0);
        check_count("evict writes", w0 + 1, writes);
        check_count("evict reads", r0 + 1, reads);
        check_word("evict write addr", line_a, last_wr_addr);
        check_line("evict write line", old_line, last_wr_line);
        access_check("reload lw +0", MEM_LW, ADDR_A, '0);
        access_check("reload lw +8", MEM_LW, ADDR_A + 8, '0);
        access_check("reload lh +6", MEM_LH, ADDR_A + 6, '0);
        check_count("reload writes", w0 + 1, writes);
        check_count("reload reads", r0 + 2, reads);
        access_check("clean evict lbu", MEM_LBU, ADDR_B + 5, '0);
        check_count("clean evict writes", w0 + 1, writes);
        check_count("clean evict reads", r0 + 3, reads);
    endtask

    // four lines on one index keep the victim path busy
    task automatic stall_soak();
        logic [31:0] r;
        mem_op_e     op;
        addr_t       a;
        word_t       d;
        for (int i = 0; i < 200; i++) begin
            rand_q = lcg_step(rand_q);
            r      = rand_q;
            op     = pick_op(r[18:16]);
            a      = SOAK_BASE + addr_t'({r[21:20], 11'h000}) + addr_t'(r[27:24]);
            if (op_size(op) == 2) begin
                a[0] = 1'b0;
            end else if (op_size(op) == 4) begin
                a[1:0] = 2'b00;
            end
            rand_q = lcg_step(rand_q);
            d      = rand_q;
            access_check($sformatf("soak %0d", i), op, a, d);
        end
    endtask

    task automatic reset_clears_lines();
        int r0;
        r0 = reads;
        access_check("reset first lw", MEM_LW, ADDR_D, '0);
        access_check("reset hit lw", MEM_LW, ADDR_D + 4, '0);
        check_count("reads before reset", r0 + 1, reads);
        apply_reset();
        compare_reset_outputs("mid-run reset");
        access_check("reset reload lw", MEM_LW, ADDR_D, '0);
        check_count("reads after reset", r0 + 2, reads);
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b0;
        req_valid_i = 1'b0;
        req_op_i    = MEM_LW;
        req_addr_i  = '0;
        req_wdata_i = '0;
        rand_q      = 32'h66e6_7105;
        errors      = 0;
        checks      = 0;
        apply_reset();
        compare_reset_outputs("power-up");
        cold_miss_then_hit();
        hit_timing();
        store_merge();
        dirty_eviction();
        stall_soak();
        reset_clears_lines();
        end_run();
    end

endmodule

/* sim/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model
    import dcache_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  mem_req_valid_i,
    output logic  mem_req_ready_o,
    input  logic  mem_req_write_i,
    input  addr_t mem_req_addr_i,
    input  line_t mem_req_line_i,
    output logic  mem_rsp_valid_o,
    output line_t mem_rsp_line_o,
    output int    read_count_o,
    output int    write_count_o,
    output addr_t last_wr_addr_o,
    output line_t last_wr_line_o
);

    line_t       lines [addr_t];
    logic [31:0] rand_q;
    logic        active;
    int          stall_left;
    int          rsp_wait;
    logic        valid_q;
    logic        ready_q;
    logic        write_q;
    addr_t       addr_q;
    line_t       line_q;
    line_t       rsp_buf;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // untouched lines read back as address xor a fixed mark
    function automatic line_t fill_pattern(input addr_t line_addr);
        line_t l;
        for (int w = 0; w < LINE_BYTES / 4; w++) begin
            l[w*32 +: 32] = (line_addr + addr_t'(w * 4)) ^ 32'ha5a5_0000;
        end
        return l;
    endfunction

    initial begin
        rand_q          = 32'h66e6_7105;
        mem_req_ready_o = 1'b0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_line_o  = '0;
        read_count_o    = 0;
        write_count_o   = 0;
        last_wr_addr_o  = '0;
        last_wr_line_o  = '0;
    end

    // everything moves on the falling edge, transfers are seen one half cycle late
    always @(negedge clk_i) begin
        if (!rst_i) begin
            mem_req_ready_o = 1'b0;
            mem_rsp_valid_o = 1'b0;
            active          = 1'b0;
            stall_left      = 0;
            rsp_wait        = 0;
            valid_q         = 1'b0;
            ready_q         = 1'b0;
        end else begin
            mem_rsp_valid_o = 1'b0;
            if (rsp_wait > 0) begin
                rsp_wait--;
                if (rsp_wait == 0) begin
                    mem_rsp_valid_o = 1'b1;
                    mem_rsp_line_o  = rsp_buf;
                end
            end
            if (valid_q && ready_q) begin
                active = 1'b0;
                if (write_q) begin
                    lines[addr_q]  = line_q;
                    last_wr_addr_o = addr_q;
                    last_wr_line_o = line_q;
                    write_count_o++;
                end else begin
                    rsp_buf  = lines.exists(addr_q) ? lines[addr_q] : fill_pattern(addr_q);
                    rsp_wait = 2;
                    read_count_o++;
                end
            end
            mem_req_ready_o = 1'b0;
            if (mem_req_valid_i) begin
                if (!active) begin
                    active     = 1'b1;
                    rand_q     = lcg_step(rand_q);
                    stall_left = int'(rand_q[17:16]);
                end
                if (stall_left == 0) begin
                    mem_req_ready_o = 1'b1;
                end else begin
                    stall_left--;
                end
            end
            valid_q = mem_req_valid_i;
            ready_q = mem_req_ready_o;
            write_q = mem_req_write_i;
            addr_q  = mem_req_addr_i;
            line_q  = mem_req_line_i;
        end
    end

endmodule

/* src/core_port.sv */
`timescale 1ns/1ps

module core_port
    import dcache_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    req_valid_i,
    input  mem_op_e req_op_i,
    input  addr_t   req_addr_i,
    input  word_t   req_wdata_i,
    output logic    req_ready_o,
    output logic    rsp_valid_o,
    output word_t   rsp_rdata_o,
    access_if.core  acc
);

    logic            busy_q;
    logic            start_q;
    logic            accept;
    mem_op_e         op_q;
    addr_t           addr_q;
    word_t           wdata_q;
    logic [OFFSET_W:0] acc_bytes;
    logic            misaligned;
    logic            line_cross;

    assign req_ready_o = !busy_q;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            busy_q      <= 1'b0;
            start_q     <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            start_q     <= accept;
            rsp_valid_o <= acc.done;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (acc.done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // request is held until the access closes
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q    <= req_op_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
        end
        if (acc.done) begin
            rsp_rdata_o <= acc.rdata;
        end
    end

    assign acc.start = start_q;
    assign acc.op    = op_q;
    assign acc.addr  = addr_q;
    assign acc.wdata = wdata_q;

    always_comb begin
        acc_bytes  = (OFFSET_W+1)'(1);
        misaligned = 1'b0;
        case (req_op_i)
            MEM_LH, MEM_LHU, MEM_SH: begin
                acc_bytes  = (OFFSET_W+1)'(2);
                misaligned = req_addr_i[0];
            end
            MEM_LW, MEM_SW: begin
                acc_bytes  = (OFFSET_W+1)'(4);
                misaligned = |req_addr_i[1:0];
            end
            default: ;
        endcase
    end

    assign line_cross = ({1'b0, req_addr_i[OFFSET_W-1:0]} + acc_bytes) > LINE_BYTES;

    // an access closes only while open and never in its own start cycle
    a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        acc.done |-> (busy_q && !start_q));

    a_in_line: assert property (@(posedge clk_i) disable iff (!rst_i)
        accept |-> (!misaligned && !line_cross));

endmodule

/* src/dcache_if.sv */
`timescale 1ns/1ps

// core request to line store and miss controller
interface access_if import dcache_pkg::*; ();

    logic    start;
    mem_op_e op;
    addr_t   addr;
    word_t   wdata;
    logic    hit;
    logic    dirty;
    addr_t   victim_addr;
    line_t   victim_line;
    logic    fill;
    line_t   fill_line;
    word_t   rdata;
    logic    done;

    modport core (
        output start, op, addr, wdata,
        input  rdata, done
    );

    modport store (
        input  start, op, addr, wdata, fill, fill_line,
        output hit, dirty, victim_addr, victim_line, rdata
    );

    modport ctrl (
        input  start, addr, hit, dirty, victim_addr, victim_line,
        output fill, fill_line, done
    );

endinterface

// miss controller to memory port
interface line_if import dcache_pkg::*; ();

    logic  req_valid;
    logic  req_ready;
    logic  write;
    addr_t addr;
    line_t line;
    logic  rsp_valid;
    line_t rsp_line;

    modport master (
        output req_valid, write, addr, line,
        input  req_ready, rsp_valid, rsp_line
    );

    modport slave (
        input  req_valid, write, addr, line,
        output req_ready, rsp_valid, rsp_line
    );

endinterface

/* src/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    localparam int LINE_BYTES = 16;
    localparam int NUM_LINES  = 128;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 7;
    localparam int TAG_W      = 21;

    typedef logic [31:0]             word_t;
    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [31:0]             addr_t;

    // bit 3 marks a store, bit 2 an unsigned load, bits 1:0 the size
    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0001,
        MEM_LW  = 4'b0010,
        MEM_LBU = 4'b0100,
        MEM_LHU = 4'b0101,
        MEM_SB  = 4'b1000,
        MEM_SH  = 4'b1001,
        MEM_SW  = 4'b1010
    } mem_op_e;

    // miss controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_WAIT,
        FILL_REQ,
        FILL_WAIT,
        REPLAY
    } miss_state_e;

endpackage

/* src/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,

    // core side
    input  logic    req_valid_i,
    input  mem_op_e req_op_i,
    input  addr_t   req_addr_i,
    input  word_t   req_wdata_i,
    output logic    req_ready_o,
    output logic    rsp_valid_o,
    output word_t   rsp_rdata_o,

    // main memory side
    output logic    mem_req_valid_o,
    input  logic    mem_req_ready_i,
    output logic    mem_req_write_o,
    output addr_t   mem_req_addr_o,
    output line_t   mem_req_line_o,
    input  logic    mem_rsp_valid_i,
    input  line_t   mem_rsp_line_i
);

    access_if acc ();
    line_if   mem_bus ();

    core_port u_core_port (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .acc         (acc.core)
    );

    line_store u_line_store (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .acc   (acc.store)
    );

    miss_ctrl u_miss_ctrl (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .acc   (acc.ctrl),
        .mem   (mem_bus.master)
    );

    mem_port u_mem_port (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .mem             (mem_bus.slave),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_write_o (mem_req_write_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_line_o  (mem_req_line_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_line_i  (mem_rsp_line_i)
    );

endmodule

/* src/line_store.sv */
`timescale 1ns/1ps

module line_store
    import dcache_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    access_if.store acc
);

    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;

    line_t              data_mem [NUM_LINES];
    logic [TAG_W-1:0]   tag_mem  [NUM_LINES];
    logic [NUM_LINES-1:0] valid_bits;
    logic [NUM_LINES-1:0] dirty_bits;

    logic                  replay_q;
    logic                  lookup;
    logic                  tag_match;
    logic                  is_store;
    logic                  merge_en;
    logic [LINE_BYTES-1:0] byte_en;
    line_t                 cur_line;
    line_t                 shifted;
    line_t                 wdata_shift;
    line_t                 merged;
    word_t                 load_val;

    logic  hit_q;
    logic  dirty_q;
    addr_t victim_addr_q;
    line_t victim_line_q;
    word_t rdata_q;

    assign offset = acc.addr[OFFSET_W-1:0];
    assign index  = acc.addr[OFFSET_W +: INDEX_W];
    assign tag    = acc.addr[OFFSET_W+INDEX_W +: TAG_W];

    // replay is the cycle right after a refill
    assign lookup    = acc.start || replay_q;
    assign cur_line  = data_mem[index];
    assign tag_match = valid_bits[index] && (tag_mem[index] == tag);
    assign shifted   = cur_line >> {offset, 3'b000};
    assign wdata_shift = line_t'(acc.wdata) << {offset, 3'b000};

    always_comb begin
        load_val = '0;
        byte_en  = '0;
        is_store = 1'b0;
        case (acc.op)
            MEM_LB:  load_val = {{24{shifted[7]}}, shifted[7:0]};
            MEM_LH:  load_val = {{16{shifted[15]}}, shifted[15:0]};
            MEM_LW:  load_val = shifted[31:0];
            MEM_LBU: load_val = {24'b0, shifted[7:0]};
            MEM_LHU: load_val = {16'b0, shifted[15:0]};
            MEM_SB: begin
                is_store = 1'b1;
                byte_en  = LINE_BYTES'(1) << offset;
            end
            MEM_SH: begin
                is_store = 1'b1;
                byte_en  = LINE_BYTES'(3) << offset;
            end
            MEM_SW: begin
                is_store = 1'b1;
                byte_en  = LINE_BYTES'(15) << offset;
            end
            default: ;
        endcase
    end

    // byte merge of store data into the resident line
    always_comb begin
        merged = cur_line;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (byte_en[b]) begin
                merged[b*8 +: 8] = wdata_shift[b*8 +: 8];
            end
        end
    end

    assign merge_en = lookup && tag_match && is_store;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            replay_q   <= 1'b0;
            hit_q      <= 1'b0;
            dirty_q    <= 1'b0;
        end else begin
            replay_q <= acc.fill;
            if (acc.fill) begin
                valid_bits[index] <= 1'b1;
                dirty_bits[index] <= 1'b0;
            end
            if (lookup) begin
                hit_q   <= tag_match;
                dirty_q <= valid_bits[index] && dirty_bits[index];
            end
            if (merge_en) begin
                dirty_bits[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (acc.fill) begin
            data_mem[index] <= acc.fill_line;
            tag_mem[index]  <= tag;
        end else if (merge_en) begin
            data_mem[index] <= merged;
        end
        if (lookup) begin
            victim_addr_q <= {tag_mem[index], index, {OFFSET_W{1'b0}}};
            victim_line_q <= cur_line;
            rdata_q       <= load_val;
        end
    end

    assign acc.hit         = hit_q;
    assign acc.dirty       = dirty_q;
    assign acc.victim_addr = victim_addr_q;
    assign acc.victim_line = victim_line_q;
    assign acc.rdata       = rdata_q;

    a_fill_no_merge: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(acc.fill && merge_en));

endmodule

/* src/mem_port.sv */
`timescale 1ns/1ps

module mem_port
    import dcache_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,
    line_if.slave  mem,
    output logic   mem_req_valid_o,
    input  logic   mem_req_ready_i,
    output logic   mem_req_write_o,
    output addr_t  mem_req_addr_o,
    output line_t  mem_req_line_o,
    input  logic   mem_rsp_valid_i,
    input  line_t  mem_rsp_line_i
);

    logic  take;
    logic  rsp_valid_q;
    line_t rsp_line_q;

    // one request in flight at most
    assign mem.req_ready = !mem_req_valid_o;
    assign take          = mem.req_valid && mem.req_ready;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            mem_req_valid_o <= 1'b0;
            rsp_valid_q     <= 1'b0;
        end else begin
            rsp_valid_q <= mem_rsp_valid_i;
            if (take) begin
                mem_req_valid_o <= 1'b1;
            end else if (mem_req_ready_i) begin
                mem_req_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            mem_req_write_o <= mem.write;
            mem_req_addr_o  <= mem.addr;
            mem_req_line_o  <= mem.line;
        end
        if (mem_rsp_valid_i) begin
            rsp_line_q <= mem_rsp_line_i;
        end
    end

    assign mem.rsp_valid = rsp_valid_q;
    assign mem.rsp_line  = rsp_line_q;

    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
        (mem_req_valid_o && !mem_req_ready_i) |=>
            (mem_req_valid_o && $stable(mem_req_write_o) &&
             $stable(mem_req_addr_o) && $stable(mem_req_line_o)));

endmodule

/* src/miss_ctrl.sv */
`timescale 1ns/1ps

module miss_ctrl
    import dcache_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    access_if.ctrl  acc,
    line_if.master  mem
);

    miss_state_e state_q;
    miss_state_e state_d;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (acc.start) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (acc.hit) begin
                    state_d = IDLE;
                end else if (acc.dirty) begin
                    state_d = WB_REQ;
                end else begin
                    state_d = FILL_REQ;
                end
            end
            WB_REQ: begin
                if (mem.req_ready) begin
                    state_d = WB_WAIT;
                end
            end
            // memory port frees up once the write is taken
            WB_WAIT: begin
                if (mem.req_ready) begin
                    state_d = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (mem.req_ready) begin
                    state_d = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                if (mem.rsp_valid) begin
                    state_d = REPLAY;
                end
            end
            // second lookup runs here, result checked in LOOKUP
            REPLAY: state_d = LOOKUP;
            default: state_d = IDLE;
        endcase
    end

    assign acc.done      = (state_q == LOOKUP) && acc.hit;
    assign acc.fill      = (state_q == FILL_WAIT) && mem.rsp_valid;
    assign acc.fill_line = mem.rsp_line;

    assign mem.req_valid = (state_q == WB_REQ) || (state_q == FILL_REQ);
    assign mem.write     = (state_q == WB_REQ);
    assign mem.addr      = mem.write ? acc.victim_addr
                                     : {acc.addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem.line      = acc.victim_line;

    a_replay_hits: assert property (@(posedge clk_i) disable iff (!rst_i)
        (state_q == REPLAY) |=> acc.hit);

endmodule
